// File: riscvPkg.sv
package riscvPkg;

	localparam int addrWidth = 12; // Byte address width of both memories

	// Major opcodes
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opReg    = 7'b0110011;
	localparam logic [6:0] opSystem = 7'b1110011;

	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Sltu   = 3'b011;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3Srl    = 3'b101; // Also SRA with f7Alt
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	// Branch conditions
	localparam logic [2:0] f3Beq  = 3'b000;
	localparam logic [2:0] f3Bne  = 3'b001;
	localparam logic [2:0] f3Blt  = 3'b100;
	localparam logic [2:0] f3Bge  = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

	localparam logic [2:0] f3Byte  = 3'b000; // LB and SB
	localparam logic [2:0] f3Word  = 3'b010;
	localparam logic [2:0] f3ByteU = 3'b100;

	localparam logic [6:0] f7Alt = 7'b0100000; // SUB and SRA

	localparam logic [3:0] aluAdd   = 4'd0;
	localparam logic [3:0] aluSub   = 4'd1;
	localparam logic [3:0] aluAnd   = 4'd2;
	localparam logic [3:0] aluOr    = 4'd3;
	localparam logic [3:0] aluXor   = 4'd4;
	localparam logic [3:0] aluSlt   = 4'd5;
	localparam logic [3:0] aluSltu  = 4'd6;
	localparam logic [3:0] aluSll   = 4'd7;
	localparam logic [3:0] aluSrl   = 4'd8;
	localparam logic [3:0] aluSra   = 4'd9;
	localparam logic [3:0] aluPassB = 4'd10; // Highest defined code

	localparam logic [1:0] wbAlu = 2'd0;
	localparam logic [1:0] wbMem = 2'd1;
	localparam logic [1:0] wbPc4 = 2'd2;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rTypeT;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iTypeT;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sTypeT;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic       imm11;
		logic [6:0] opcode;
	} bTypeT;

	typedef struct packed {
		logic [19:0] imm; // Upper 20 bits of the result
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} uTypeT;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10to1;
		logic       imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jTypeT;

	typedef union packed {
		rTypeT rType;
		iTypeT iType;
		sTypeT sType;
		bTypeT bType;
		uTypeT uType;
		jTypeT jType;
	} instrWord;

endpackage

// File: ctrlIf.sv
interface ctrlIf (
	input logic CLK // Sampling clock for checks in the datapath
);
	logic [3:0]  aluOp;
	logic        aluSrcImm;    // Operand B from imm
	logic        aluSrcPc;     // Operand A from pc
	logic        regWrite;
	logic        memWrite;
	logic        memRead;
	logic        memByte;      // Byte access instead of word
	logic        loadUnsigned;
	logic [1:0]  wbSel;
	logic        branch;
	logic        jal;
	logic        jalr;
	logic        halt;
	logic [31:0] imm;
	logic [2:0]  funct3;

	modport decoder (
		output aluOp, aluSrcImm, aluSrcPc, regWrite, memWrite, memRead, memByte,
		output loadUnsigned, wbSel, branch, jal, jalr, halt, imm, funct3
	);

	modport datapath (
		input CLK,
		input aluOp, aluSrcImm, aluSrcPc, regWrite, memWrite, memRead, memByte,
		input loadUnsigned, wbSel, branch, jal, jalr, halt, imm, funct3
	);
endinterface

// File: instrDecode.sv
module instrDecode import riscvPkg::*; (
	input  instrWord       instr,
	ctrlIf.decoder         ctl,
	output logic [4:0]     rs1,
	output logic [4:0]     rs2,
	output logic [4:0]     rd
);
	logic [6:0]  opcode;
	logic [2:0]  f3;
	logic        isAlt;
	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immU;
	logic [31:0] immJ;

	// Register-register and register-immediate share this mapping
	function automatic logic [3:0] aluDecode(input logic [2:0] fn, input logic alt);
		logic [3:0] op;
		case (fn)
			f3AddSub: op = alt ? aluSub : aluAdd;
			f3Sll:    op = aluSll;
			f3Slt:    op = aluSlt;
			f3Sltu:   op = aluSltu;
			f3Xor:    op = aluXor;
			f3Srl:    op = alt ? aluSra : aluSrl;
			f3Or:     op = aluOr;
			f3And:    op = aluAnd;
			default:  op = aluAdd;
		endcase
		return op;
	endfunction

	assign opcode = instr.rType.opcode;
	assign f3     = instr.rType.funct3;
	assign isAlt  = instr.rType.funct7 == f7Alt;

	assign rs1 = instr.rType.rs1;
	assign rs2 = instr.rType.rs2;
	assign rd  = instr.rType.rd;

	assign immI = {{20{instr.iType.imm[11]}}, instr.iType.imm};
	assign immS = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
	assign immB = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
		instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
	assign immU = {instr.uType.imm, 12'b0};
	assign immJ = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19to12,
		instr.jType.imm11, instr.jType.imm10to1, 1'b0};

	assign ctl.funct3 = f3; // Branch condition for the ALU

	always_comb begin
		// Defaults give a plain pc+4 step with no writes
		ctl.aluOp        = aluAdd;
		ctl.aluSrcImm    = 1'b0;
		ctl.aluSrcPc     = 1'b0;
		ctl.regWrite     = 1'b0;
		ctl.memWrite     = 1'b0;
		ctl.memRead      = 1'b0;
		ctl.memByte      = 1'b0;
		ctl.loadUnsigned = 1'b0;
		ctl.wbSel        = wbAlu;
		ctl.branch       = 1'b0;
		ctl.jal          = 1'b0;
		ctl.jalr         = 1'b0;
		ctl.halt         = 1'b0;
		ctl.imm          = '0;
		case (opcode)
			opLui: begin
				ctl.regWrite  = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.aluOp     = aluPassB;
				ctl.imm       = immU;
			end
			opAuipc: begin
				ctl.regWrite  = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.aluSrcPc  = 1'b1; // pc + upper imm
				ctl.imm       = immU;
			end
			opJal: begin
				ctl.regWrite = 1'b1;
				ctl.jal      = 1'b1;
				ctl.wbSel    = wbPc4;
				ctl.imm      = immJ;
			end
			opJalr: begin
				ctl.regWrite  = 1'b1;
				ctl.jalr      = 1'b1;
				ctl.wbSel     = wbPc4;
				ctl.aluSrcImm = 1'b1; // Target is rs1 + imm
				ctl.imm       = immI;
			end
			opBranch: begin
				ctl.branch = 1'b1;
				ctl.imm    = immB;
			end
			opLoad: begin
				// Halfword loads fall through as no-ops
				if (f3 == f3Word || f3 == f3Byte || f3 == f3ByteU) begin
					ctl.regWrite     = 1'b1;
					ctl.memRead      = 1'b1;
					ctl.memByte      = f3 != f3Word;
					ctl.loadUnsigned = f3 == f3ByteU;
					ctl.wbSel        = wbMem;
					ctl.aluSrcImm    = 1'b1;
					ctl.imm          = immI;
				end
			end
			opStore: begin
				if (f3 == f3Word || f3 == f3Byte) begin
					ctl.memWrite  = 1'b1;
					ctl.memByte   = f3 == f3Byte;
					ctl.aluSrcImm = 1'b1;
					ctl.imm       = immS;
				end
			end
			opImm: begin
				ctl.regWrite  = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.aluOp     = aluDecode(f3, isAlt && (f3 == f3Srl)); // ADDI has no SUB form
				ctl.imm       = immI;
			end
			opReg: begin
				ctl.regWrite = 1'b1;
				ctl.aluOp    = aluDecode(f3, isAlt);
			end
			opSystem: begin
				// EBREAK only
				ctl.halt = instr.iType.imm == 12'h001 && instr.iType.funct3 == 3'b000;
			end
			default: ;
		endcase
	end
endmodule

// File: alu.sv
module alu import riscvPkg::*; (
	input  logic [31:0] a,
	input  logic [31:0] b,
	ctrlIf.datapath     ctl,
	output logic [31:0] y,
	output logic        take
);
	logic [4:0] shamt;
	logic       isEq;
	logic       isLt;
	logic       isLtu;

	assign shamt = b[4:0];
	assign isEq  = a == b;
	assign isLt  = $signed(a) < $signed(b);
	assign isLtu = a < b;

	always_comb begin
		case (ctl.aluOp)
			aluAdd:   y = a + b;
			aluSub:   y = a - b;
			aluAnd:   y = a & b;
			aluOr:    y = a | b;
			aluXor:   y = a ^ b;
			aluSlt:   y = {31'b0, isLt};
			aluSltu:  y = {31'b0, isLtu};
			aluSll:   y = a << shamt;
			aluSrl:   y = a >> shamt;
			aluSra:   y = $signed(a) >>> shamt;
			aluPassB: y = b; // LUI
			default:  y = '0;
		endcase
	end

	// Compares rs1 against rs2, used by pcUnit only for branches
	always_comb begin
		case (ctl.funct3)
			f3Beq:   take = isEq;
			f3Bne:   take = !isEq;
			f3Blt:   take = isLt;
			f3Bge:   take = !isLt;
			f3Bltu:  take = isLtu;
			f3Bgeu:  take = !isLtu;
			default: take = 1'b0;
		endcase
	end

	// Decoder must never hand over an unassigned code
	aluOpDefined: assert property (@(posedge ctl.CLK) ctl.aluOp <= aluPassB)
		else $error("alu: undefined aluOp %0d", ctl.aluOp);
endmodule

// File: pcUnit.sv
module pcUnit import riscvPkg::*; #(
	parameter int addrWidth = riscvPkg::addrWidth
) (
	input  logic                 CLK,
	input  logic                 RSTn,
	ctrlIf.datapath              ctl,
	input  logic                 take,
	input  logic [31:0]          aluY,
	output logic [addrWidth-1:0] pc,
	output logic [31:0]          pcPlus4,
	output logic [31:0]          numInst
);
	logic [31:0] pcExt;
	logic [31:0] pcTarget;
	logic [31:0] nextPc;

	assign pcExt    = 32'(pc);
	assign pcPlus4  = pcExt + 32'd4;
	assign pcTarget = pcExt + ctl.imm; // JAL and branch target

	always_comb begin
		if (ctl.halt) begin
			nextPc = pcExt; // Stay on EBREAK
		end else if (ctl.jalr) begin
			nextPc = {aluY[31:1], 1'b0};
		end else if (ctl.jal || (ctl.branch && take)) begin
			nextPc = pcTarget;
		end else begin
			nextPc = pcPlus4;
		end
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc      <= '0;
			numInst <= '0;
		end else begin
			pc <= nextPc[addrWidth-1:0];
			if (!ctl.halt) begin
				numInst <= numInst + 32'd1; // One retired per cycle
			end
		end
	end

	// Jump and branch targets from the decoder keep word alignment
	pcAligned: assert property (@(posedge CLK) disable iff (RSTn) pc[1:0] == 2'b00)
		else $error("pcUnit: misaligned pc 0x%0h", pc);
endmodule

// File: lsUnit.sv
module lsUnit import riscvPkg::*; #(
	parameter int addrWidth = riscvPkg::addrWidth
) (
	ctrlIf.datapath              ctl,
	input  logic [31:0]          addr,
	input  logic [31:0]          storeData,
	input  logic [31:0]          memRdata,
	output logic [addrWidth-3:0] memAddr,
	output logic [3:0]           memBe,
	output logic [31:0]          memWdata,
	output logic                 memCsn,
	output logic [31:0]          loadData
);
	logic [1:0] byteSel;
	logic [7:0] loadByte;
	logic       signBit;

	assign byteSel = addr[1:0];
	assign memAddr = addr[addrWidth-1:2]; // Word address

	assign memBe    = ctl.memByte ? (4'b0001 << byteSel) : 4'b1111;
	assign memWdata = ctl.memByte ? {4{storeData[7:0]}} : storeData; // Lane picked by memBe
	assign memCsn   = !(ctl.memRead || ctl.memWrite);

	// Byte lane of the addressed word
	assign loadByte = memRdata[{byteSel, 3'b000} +: 8];
	assign signBit  = loadByte[7] && !ctl.loadUnsigned;

	always_comb begin
		if (ctl.memByte) begin
			loadData = {{24{signBit}}, loadByte};
		end else begin
			loadData = memRdata;
		end
	end

	// Store strobes reach the memory as a single lane or the full word
	beLegal: assert property (@(posedge ctl.CLK)
		ctl.memWrite |-> (memBe == 4'b1111 || $onehot(memBe)))
		else $error("lsUnit: illegal byte enables %b", memBe);
endmodule

// File: riscvTop.sv
module riscvTop import riscvPkg::*; #(
	parameter int addrWidth = riscvPkg::addrWidth
) (
	input  logic                 CLK,
	input  logic                 RSTn,

	output logic                 iMemCsn,
	output logic [addrWidth-1:0] iMemAddr, // Byte address
	input  logic [31:0]          iMemDi,

	output logic                 dMemCsn,
	output logic [addrWidth-3:0] dMemAddr, // Word address
	output logic [31:0]          dMemDout,
	output logic                 dMemWen,
	output logic [3:0]           dMemBe,
	input  logic [31:0]          dMemDi,

	output logic                 rfWe,
	output logic [4:0]           rfRa1,
	output logic [4:0]           rfRa2,
	output logic [4:0]           rfWa,
	output logic [31:0]          rfWd,
	input  logic [31:0]          rfRd1,
	input  logic [31:0]          rfRd2,

	output logic                 halt,
	output logic [31:0]          numInst,
	output logic [31:0]          outputPort
);
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] aluY;
	logic        take;
	logic [31:0] pcPlus4;
	logic [31:0] loadData;

	ctrlIf ctl (.CLK(CLK));

	instrDecode uDecode (
		.instr(iMemDi),
		.ctl  (ctl.decoder),
		.rs1  (rfRa1),
		.rs2  (rfRa2),
		.rd   (rfWa)
	);

	// AUIPC adds to pc, everything else starts from rs1
	assign opA = ctl.aluSrcPc ? 32'(iMemAddr) : rfRd1;
	assign opB = ctl.aluSrcImm ? ctl.imm : rfRd2;

	alu uAlu (
		.a   (opA),
		.b   (opB),
		.ctl (ctl.datapath),
		.y   (aluY),
		.take(take)
	);

	pcUnit #(.addrWidth(addrWidth)) uPc (
		.CLK    (CLK),
		.RSTn   (RSTn),
		.ctl    (ctl.datapath),
		.take   (take),
		.aluY   (aluY),
		.pc     (iMemAddr),
		.pcPlus4(pcPlus4),
		.numInst(numInst)
	);

	lsUnit #(.addrWidth(addrWidth)) uLs (
		.ctl      (ctl.datapath),
		.addr     (aluY),
		.storeData(rfRd2),
		.memRdata (dMemDi),
		.memAddr  (dMemAddr),
		.memBe    (dMemBe),
		.memWdata (dMemDout),
		.memCsn   (dMemCsn),
		.loadData (loadData)
	);

	always_comb begin
		case (ctl.wbSel)
			wbMem:   rfWd = loadData;
			wbPc4:   rfWd = pcPlus4; // Link value
			default: rfWd = aluY;
		endcase
	end

	// No writes in the reset cycle or once halted
	assign rfWe    = ctl.regWrite && !ctl.halt && !RSTn;
	assign dMemWen = ctl.memWrite && !ctl.halt && !RSTn;

	assign iMemCsn    = 1'b0; // Fetch every cycle
	assign halt       = ctl.halt;
	assign outputPort = rfWd;
endmodule

// File: tbRiscv.sv
module tbRiscv;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int addrWidth = 12;
	localparam int memWords = 2 ** (addrWidth - 2);
	localparam int numInstr = 40; // Program length with the EBREAK
	localparam int maxCycles = 200;
	localparam logic [31:0] ebreakWord = 32'h00100073;

	logic                 CLK;
	logic                 RSTn;
	logic                 iMemCsn;
	logic [addrWidth-1:0] iMemAddr;
	logic [31:0]          iMemDi;
	logic                 dMemCsn;
	logic [addrWidth-3:0] dMemAddr;
	logic [31:0]          dMemDout;
	logic                 dMemWen;
	logic [3:0]           dMemBe;
	logic [31:0]          dMemDi;
	logic                 rfWe;
	logic [4:0]           rfRa1;
	logic [4:0]           rfRa2;
	logic [4:0]           rfWa;
	logic [31:0]          rfWd;
	logic [31:0]          rfRd1;
	logic [31:0]          rfRd2;
	logic                 halt;
	logic [31:0]          numInst;
	logic [31:0]          outputPort;

	logic [31:0] imem [memWords];
	logic [31:0] dmem [memWords];
	logic [31:0] dmemInit [memWords]; // Loaded into dmem during reset
	logic [31:0] rf [32];
	logic [31:0] rfInit [32];

	// Reference model state and the expectations of the current instruction
	logic [31:0]          mReg [32];
	logic [31:0]          mMem [memWords];
	logic [31:0]          mPc;
	logic [31:0]          mCount;
	logic                 eWe;
	logic [4:0]           eWa;
	logic [31:0]          eWd;
	logic                 eMemWen;
	logic [addrWidth-1:0] eMemAddr;
	logic [3:0]           eBe;
	logic [31:0]          eDout;
	logic                 eHalt;
	logic                 eMemSel; // Load or store selects the data memory

	logic [31:0] rngState;
	int          errCount;
	int          testCount;
	int          failCount;
	string       curTest;

	riscvTop #(.addrWidth(addrWidth)) i_riscvTop (
		.CLK(CLK), .RSTn(RSTn),
		.iMemCsn(iMemCsn), .iMemAddr(iMemAddr), .iMemDi(iMemDi),
		.dMemCsn(dMemCsn), .dMemAddr(dMemAddr), .dMemDout(dMemDout),
		.dMemWen(dMemWen), .dMemBe(dMemBe), .dMemDi(dMemDi),
		.rfWe(rfWe), .rfRa1(rfRa1), .rfRa2(rfRa2), .rfWa(rfWa), .rfWd(rfWd),
		.rfRd1(rfRd1), .rfRd2(rfRd2),
		.halt(halt), .numInst(numInst), .outputPort(outputPort)
	);

	initial CLK = 1'b0;
	always #50 CLK = !CLK;

	assign iMemDi = imem[iMemAddr[addrWidth-1:2]];
	assign dMemDi = dmem[dMemAddr];
	assign rfRd1  = (rfRa1 == 5'd0) ? 32'd0 : rf[rfRa1]; // x0 reads zero
	assign rfRd2  = (rfRa2 == 5'd0) ? 32'd0 : rf[rfRa2];

	always @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < memWords; i++) begin
				dmem[i] <= dmemInit[i];
			end
			for (int i = 0; i < 32; i++) begin
				rf[i] <= rfInit[i];
			end
		end else begin
			if (dMemWen && !dMemCsn) begin
				for (int k = 0; k < 4; k++) begin
					if (dMemBe[k]) begin
						dmem[dMemAddr][8*k +: 8] <= dMemDout[8*k +: 8];
					end
				end
			end
			if (rfWe && rfWa != 5'd0) begin
				rf[rfWa] <= rfWd;
			end
		end
	end

	function automatic logic [31:0] lcgNext();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	function automatic int randBelow(input int n);
		return int'(lcgNext() >> 16) % n; // Upper bits are the better ones
	endfunction

	function automatic logic [4:0] randReg();
		return 5'(randBelow(7) + 1); // x1 to x7
	endfunction

	// RV32I arithmetic from the ISA rules
	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end else begin
					return a >> b[4:0];
				end
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic checkWord(input string field, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("Mismatch %s %s: expected 0x%08h, actual 0x%08h", curTest, field, exp, act);
			errCount++;
		end
	endtask

	task automatic checkAddr(input string field, input logic [addrWidth-1:0] exp,
		input logic [addrWidth-1:0] act);
		if (act !== exp) begin
			$display("Mismatch %s %s: expected 0x%03h, actual 0x%03h", curTest, field, exp, act);
			errCount++;
		end
	endtask

	task automatic checkCount(input string field, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("Mismatch %s %s: expected %0d, actual %0d", curTest, field, exp, act);
			errCount++;
		end
	endtask

	task automatic reportTest(input int errStart);
		testCount++;
		if (errCount == errStart) begin
			$display("PASS %s", curTest);
		end else begin
			failCount++;
			$display("FAIL %s with %0d errors", curTest, errCount - errStart);
		end
	endtask

	task automatic fillMemories();
		for (int i = 0; i < memWords; i++) begin
			imem[i] = {20'(i), 12'h000}; // Opcode 0 decodes to no operation
			dmemInit[i] = 32'(i) * 32'h9E3779B1 ^ 32'h5A5A0000;
		end
		for (int i = 0; i < 32; i++) begin
			rfInit[i] = 32'd0;
		end
	endtask

	task automatic genProgram();
		int          kind;
		int          skip;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm12;
		logic [12:0] offB;
		logic [20:0] offJ;
		logic [31:0] r32;
		logic [31:0] w;
		for (int i = 1; i < 32; i++) begin
			rfInit[i] = lcgNext();
		end
		for (int i = 0; i < numInstr - 1; i++) begin
			rd    = randReg();
			rs1   = randReg();
			rs2   = randReg();
			f3    = 3'(randBelow(8));
			alt   = randBelow(2) == 1;
			imm12 = 12'(lcgNext() >> 20);
			r32   = lcgNext();
			skip  = 2 + randBelow(3); // 8, 12 or 16 bytes ahead
			kind  = randBelow(12);
			if (kind >= 5 && kind <= 7 && i + skip > numInstr - 1) begin
				kind = 0; // Jump would pass the EBREAK
			end
			offB = 13'(skip * 4);
			offJ = 21'(skip * 4);
			case (kind)
				0, 1: w = {((f3 == 3'd0 || f3 == 3'd5) && alt) ? 7'h20 : 7'h00,
					rs2, rs1, f3, rd, 7'h33};
				2, 3: begin
					if (f3 == 3'd1) begin
						imm12 = {7'h00, imm12[4:0]};
					end else if (f3 == 3'd5) begin
						imm12 = {alt ? 7'h20 : 7'h00, imm12[4:0]};
					end
					w = {imm12, rs1, f3, rd, 7'h13};
				end
				4: w = {r32[31:12], rd, alt ? 7'h17 : 7'h37}; // AUIPC or LUI
				5: w = {offJ[20], offJ[10:1], offJ[11], offJ[19:12], rd, 7'h6F};
				6: w = {12'((i + skip) * 4), 5'd0, 3'b000, rd, 7'h67}; // Absolute via x0
				7: begin
					if (f3 == 3'd2 || f3 == 3'd3) begin
						f3 = f3 ^ 3'b110;
					end
					w = {offB[12], offB[10:5], rs2, rs1, f3, offB[4:1], offB[11], 7'h63};
				end
				8: w = {4'd0, imm12[7:2], 2'b00, 5'd0, 3'b010, rd, 7'h03};
				9: w = {4'd0, imm12[7:0], 5'd0, alt ? 3'b100 : 3'b000, rd, 7'h03};
				10: begin
					imm12 = {4'd0, imm12[7:2], 2'b00};
					w = {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], 7'h23};
				end
				default: w = {4'd0, imm12[7:5], rs2, 5'd0, 3'b000, imm12[4:0], 7'h23};
			endcase
			imem[i] = w;
		end
		imem[numInstr-1] = ebreakWord;
		for (int i = 0; i < 32; i++) begin
			mReg[i] = (i == 0) ? 32'd0 : rfInit[i];
		end
		for (int i = 0; i < memWords; i++) begin
			mMem[i] = dmemInit[i];
		end
		mPc    = 32'd0;
		mCount = 32'd0;
	endtask

	// Executes the instruction at mPc and leaves its expected outputs in the e* signals
	task automatic modelStep();
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [31:0] addr;
		logic [31:0] word;
		logic [31:0] nextPc;
		logic [7:0]  byteVal;
		logic        cond;
		w       = imem[mPc[addrWidth-1:2]];
		a       = mReg[w[19:15]];
		b       = mReg[w[24:20]];
		immI    = {{20{w[31]}}, w[31:20]};
		immS    = {{20{w[31]}}, w[31:25], w[11:7]};
		immB    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		immJ    = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		nextPc  = mPc + 32'd4;
		eWe     = 1'b0;
		eWa     = w[11:7];
		eWd     = 32'd0;
		eMemWen = 1'b0;
		eMemSel = 1'b0;
		eBe     = 4'd0;
		eDout   = 32'd0;
		eHalt   = w == ebreakWord;
		case (w[6:0])
			7'h33: begin
				eWe = 1'b1;
				eWd = aluRef(w[14:12], w[30], a, b);
			end
			7'h13: begin
				eWe = 1'b1;
				eWd = aluRef(w[14:12], w[30] && w[14:12] == 3'd5, a, immI); // Only SRAI
			end
			7'h37: begin
				eWe = 1'b1;
				eWd = {w[31:12], 12'h000};
			end
			7'h17: begin
				eWe = 1'b1;
				eWd = mPc + {w[31:12], 12'h000};
			end
			7'h6F: begin
				eWe    = 1'b1;
				eWd    = mPc + 32'd4;
				nextPc = mPc + immJ;
			end
			7'h67: begin
				eWe    = 1'b1;
				eWd    = mPc + 32'd4;
				nextPc = (a + immI) & ~32'd1;
			end
			7'h63: begin
				case (w[14:12])
					3'd0: cond = a == b;
					3'd1: cond = a != b;
					3'd4: cond = $signed(a) < $signed(b);
					3'd5: cond = $signed(a) >= $signed(b);
					3'd6: cond = a < b;
					default: cond = a >= b;
				endcase
				if (cond) begin
					nextPc = mPc + immB;
				end
			end
			7'h03: begin
				addr    = a + immI;
				word    = mMem[addr[addrWidth-1:2]];
				byteVal = word[{addr[1:0], 3'b000} +: 8];
				eWe     = 1'b1;
				eMemSel = 1'b1;
				if (w[14:12] == 3'b010) begin
					eWd = word;
				end else if (w[14:12] == 3'b100) begin
					eWd = {24'd0, byteVal};
				end else begin
					eWd = {{24{byteVal[7]}}, byteVal};
				end
			end
			7'h23: begin
				addr     = a + immS;
				eMemWen  = 1'b1;
				eMemSel  = 1'b1;
				eMemAddr = {2'b00, addr[addrWidth-1:2]};
				if (w[14:12] == 3'b010) begin
					eBe   = 4'hF;
					eDout = b;
					mMem[addr[addrWidth-1:2]] = b;
				end else begin
					eBe   = 4'b0001 << addr[1:0];
					eDout = {4{b[7:0]}}; // Byte copied into every lane
					mMem[addr[addrWidth-1:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
				end
			end
			default: ;
		endcase
		if (!eHalt) begin
			if (eWe && eWa != 5'd0) begin
				mReg[eWa] = eWd;
			end
			mCount = mCount + 32'd1;
			mPc    = nextPc;
		end
	endtask

	task automatic runProgram(input int progNum);
		int   errStart;
		logic done;
		@(posedge CLK);
		RSTn <= 1'b1;
		@(negedge CLK);
		genProgram(); // Writes are blocked while in reset
		repeat (9) @(posedge CLK);
		@(negedge CLK);
		curTest  = $sformatf("reset%0d", progNum);
		errStart = errCount;
		checkAddr("iMemAddr", '0, iMemAddr);
		checkCount("numInst", 32'd0, numInst);
		checkWord("rfWe", 32'd0, {31'd0, rfWe});
		checkWord("dMemWen", 32'd0, {31'd0, dMemWen});
		reportTest(errStart);
		@(posedge CLK);
		RSTn <= 1'b0;
		curTest  = $sformatf("program%0d", progNum);
		errStart = errCount;
		done     = 1'b0;
		for (int cyc = 0; cyc < maxCycles && !done; cyc++) begin
			@(negedge CLK);
			checkAddr("iMemAddr", mPc[addrWidth-1:0], iMemAddr);
			checkWord("iMemCsn", 32'd0, {31'd0, iMemCsn});
			modelStep();
			checkWord("halt", {31'd0, eHalt}, {31'd0, halt});
			if (eHalt || halt) begin
				done = 1'b1;
			end else begin
				checkWord("rfWe", {31'd0, eWe}, {31'd0, rfWe});
				checkWord("dMemWen", {31'd0, eMemWen}, {31'd0, dMemWen});
				checkWord("dMemCsn", {31'd0, !eMemSel}, {31'd0, dMemCsn});
				if (eWe && rfWe) begin
					checkWord("rfWa", {27'd0, eWa}, {27'd0, rfWa});
					checkWord("rfWd", eWd, rfWd);
					checkWord("outputPort", eWd, outputPort);
				end
				if (eMemWen && dMemWen) begin
					checkAddr("dMemAddr", eMemAddr, {2'b00, dMemAddr});
					checkWord("dMemBe", {28'd0, eBe}, {28'd0, dMemBe});
					checkWord("dMemDout", eDout, dMemDout);
				end
			end
		end
		if (done) begin
			checkCount("numInst", mCount, numInst);
			@(negedge CLK);
			checkAddr("held iMemAddr", mPc[addrWidth-1:0], iMemAddr);
			checkCount("held numInst", mCount, numInst);
			checkWord("held halt", 32'd1, {31'd0, halt});
		end else begin
			$display("Timeout in %s: halt never rose within %0d cycles", curTest, maxCycles);
			errCount++;
		end
		reportTest(errStart);
	endtask

	initial begin
		RSTn      = 1'b1;
		rngState  = 32'd68;
		errCount  = 0;
		testCount = 0;
		failCount = 0;
		fillMemories();
		for (int p = 0; p < 3; p++) begin
			runProgram(p);
		end
		$display("Tests run: %0d, failed: %0d, errors: %0d", testCount, failCount, errCount);
		if (errCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end
endmodule

// File: list.f
riscvPkg.sv
ctrlIf.sv
instrDecode.sv
alu.sv
pcUnit.sv
lsUnit.sv
riscvTop.sv
tbRiscv.sv

// File: run.sh
#!/bin/bash
# Builds with Verilator and runs the testbench; exit status follows the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tbRiscv -f list.f -o simRiscv \
	&& ./obj_dir/simRiscv | tee /dev/stderr | grep -q "^TESTS PASSED$" \
	&& echo "Simulation passed" && exit 0 \
	|| { echo "Simulation failed"; exit 1; }
